/* alu_core.f */
verilog/alu_pkg.sv
verilog/alu_issue.sv
verilog/alu_logic_unit.sv
verilog/alu_adder_unit.sv
verilog/alu_shift_unit.sv
verilog/alu_execute.sv
verilog/alu_flag_commit.sv
verilog/alu_top.sv
verification/alu_properties.sv
verification/alu_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module alu_tb -f alu_core.f -o alu_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/alu_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi

echo "Simulation finished"
exit 0

/* verification/alu_properties.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_properties
  import alu_pkg::*;
(
  input logic       clk,
  input logic       rst_n_i,
  input logic       flush_i,
  input logic       alu_ready_i,
  input logic       mem_ready_i,
  input logic       result_valid_i,
  input alu_data_t  result_i,
  input alu_flags_t flags_i
);

  // Output register holds while the memory side stalls
  a_hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
    (result_valid_i && !mem_ready_i && !flush_i) |=> (result_valid_i && $stable(result_i)))
    else $error("result dropped or changed while mem_ready_i was low");

  // No load into the result register, no flag change
  a_flags_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
    (flush_i || (result_valid_i && !mem_ready_i)) |=> $stable(flags_i))
    else $error("flags changed without a new result");

  a_flags_with_result: assert property (@(posedge clk) disable iff (!rst_n_i)
    !$stable(flags_i) |-> result_valid_i)
    else $error("flags changed while no result was held");

  a_idle_after_reset: assert property (@(posedge clk)
    !rst_n_i |=> !result_valid_i)
    else $error("result_valid_o high after reset");

  a_ready_after_reset: assert property (@(posedge clk)
    !rst_n_i |=> alu_ready_i)
    else $error("alu_ready_o low after reset");

  a_idle_after_flush: assert property (@(posedge clk)
    (rst_n_i && flush_i) |=> !result_valid_i)
    else $error("result_valid_o high after flush");

endmodule

bind alu_top alu_properties u_alu_properties (
  .clk            (clk),
  .rst_n_i        (rst_n_i),
  .flush_i        (flush_i),
  .alu_ready_i    (alu_ready_o),
  .mem_ready_i    (mem_ready_i),
  .result_valid_i (result_valid_o),
  .result_i       (result_o),
  .flags_i        (flags_o)
);

`default_nettype wire

/* verification/alu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_tb
  import alu_pkg::*;
;

  localparam int CLK_PERIOD    = 20;
  localparam int N_LOGIC       = 150;
  localparam int N_EDGE        = 50;
  localparam int N_SHIFT       = 48;
  localparam int N_MASKED      = 250;
  localparam int N_AFTER_FLUSH = 8;
  // One extra for the explicit NEG of 0x80
  localparam int EXPECTED_RESULTS = N_LOGIC + 1 + N_EDGE + N_SHIFT + N_MASKED + N_AFTER_FLUSH;
  // Per-operation budget that covers random stalls
  localparam int WATCHDOG_NS = (EXPECTED_RESULTS * 12 + 100) * CLK_PERIOD;

  typedef struct packed {
    alu_data_t  result;
    alu_flags_t flags;
  } expect_t;

  logic       clk;
  logic       rst_n_i;
  logic       flush_i;
  logic       req_valid_i;
  alu_req_t   req_i;
  logic       alu_ready_o;
  logic       mem_ready_i;
  logic       result_valid_o;
  alu_data_t  result_o;
  alu_flags_t flags_o;

  // Reference queue kept as a ring buffer
  expect_t     exp_mem [0:63];
  logic [5:0]  wr_ptr;
  logic [5:0]  rd_ptr;
  expect_t     head;
  expect_t     incoming;
  alu_flags_t  ref_flags;
  alu_flags_t  last_flags;
  int          pop_count;
  logic        random_stalls;
  int unsigned seed_ret;
  int          i;
  int          j;

  alu_top u_alu_top (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .flush_i        (flush_i),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .alu_ready_o    (alu_ready_o),
    .mem_ready_i    (mem_ready_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .flags_o        (flags_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic expect_t predict_outcome(input alu_req_t r, input alu_flags_t prev);
    expect_t    e;
    alu_data_t  res;
    alu_flags_t raw;
    logic       legal;
    int         wide;
    int         ssum;
    int         k;
    res   = '0;
    raw   = '0;
    legal = 1'b1;
    wide  = 0;
    ssum  = 0;
    case (r.opcode)
      OPC_AND: res = r.a & r.b;
      OPC_OR:  res = r.a | r.b;
      OPC_XOR: res = r.a ^ r.b;
      OPC_NOT: res = ~r.a;
      OPC_NEG:
      begin
        res          = alu_data_t'(0 - int'(r.a));
        raw.overflow = (r.a == 8'h80);
      end
      OPC_ADD, OPC_SUB:
      begin
        // Unsigned range gives carry or borrow and signed range gives overflow
        if (r.opcode == OPC_ADD)
        begin
          wide      = int'(r.a) + int'(r.b);
          ssum      = int'($signed(r.a)) + int'($signed(r.b));
          raw.carry = (wide > 255);
        end
        else
        begin
          wide      = int'(r.a) - int'(r.b);
          ssum      = int'($signed(r.a)) - int'($signed(r.b));
          raw.carry = (wide < 0);
        end
        raw.overflow = (ssum > 127) || (ssum < -128);
        res          = alu_data_t'(wide);
      end
      OPC_LSR, OPC_LSL, OPC_ASR:
      begin
        // Carry keeps the last bit that falls off
        res = r.a;
        for (k = 0; k < int'(r.b[SHAMT_WIDTH-1:0]); k++)
        begin
          if (r.opcode == OPC_LSL)
          begin
            raw.carry = res[DATA_WIDTH-1];
            res       = {res[DATA_WIDTH-2:0], 1'b0};
          end
          else
          begin
            raw.carry = res[0];
            res       = {(r.opcode == OPC_ASR) & res[DATA_WIDTH-1], res[DATA_WIDTH-1:1]};
          end
        end
      end
      OPC_MOV: res = r.b;
      default: legal = 1'b0;
    endcase
    e.result = res;
    e.flags  = prev;
    if (legal)
    begin
      if (r.opcode != OPC_MOV)
      begin
        raw.zero     = (res == '0);
        raw.negative = res[DATA_WIDTH-1];
      end
      if (r.mask[FLAG_ZERO])
        e.flags.zero = raw.zero;
      if (r.mask[FLAG_NEG])
        e.flags.negative = raw.negative;
      if (r.mask[FLAG_OVER])
        e.flags.overflow = raw.overflow;
      if (r.mask[FLAG_CARRY])
        e.flags.carry = raw.carry;
    end
    return e;
  endfunction

  function automatic alu_req_t make_req(input alu_opcode_t op, input alu_data_t a,
                                        input alu_data_t b, input logic [3:0] mask);
    alu_req_t r;
    r.opcode = op;
    r.a      = a;
    r.b      = b;
    r.mask   = mask;
    return r;
  endfunction

  function automatic alu_data_t rand_byte();
    return alu_data_t'($urandom);
  endfunction

  function automatic alu_data_t edge_operand(input int k);
    case (k)
      0:       return 8'h00;
      1:       return 8'h01;
      2:       return 8'h7f;
      3:       return 8'h80;
      default: return 8'hff;
    endcase
  endfunction

  function automatic alu_opcode_t shift_opcode(input int k);
    case (k)
      0:       return OPC_LSR;
      1:       return OPC_LSL;
      default: return OPC_ASR;
    endcase
  endfunction

  task automatic stop_with_error(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    $display("tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic drive_ready();
    if (random_stalls)
    begin
      mem_ready_i = ($urandom_range(0, 99) < 60);
    end
  endtask

  task automatic idle_cycle();
    drive_ready();
    @(posedge clk);
    #2;
  endtask

  // Holds the request until alu_ready_o is seen high before an edge
  task automatic send_request(input alu_req_t r);
    logic accepted;
    accepted    = 1'b0;
    req_i       = r;
    req_valid_i = 1'b1;
    while (!accepted)
    begin
      drive_ready();
      @(negedge clk);
      accepted = alu_ready_o;
      @(posedge clk);
      #2;
    end
    req_valid_i = 1'b0;
  endtask

  task automatic drain_pipeline();
    while (rd_ptr != wr_ptr)
    begin
      idle_cycle();
    end
  endtask

  always_comb
  begin
    incoming = predict_outcome(req_i, ref_flags);
  end

  assign head = exp_mem[rd_ptr];

  // Reference bookkeeping on the clock edge
  always @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      ref_flags  <= '0;
      last_flags <= '0;
      pop_count  <= 0;
    end
    else if (flush_i)
    begin
      // Flushed items never reach the output
      wr_ptr    <= rd_ptr;
      // Flags already include the item held in commit
      ref_flags <= result_valid_o ? head.flags : last_flags;
    end
    else
    begin
      if (req_valid_i && alu_ready_o)
      begin
        exp_mem[wr_ptr] <= incoming;
        ref_flags       <= incoming.flags;
        wr_ptr          <= wr_ptr + 6'd1;
      end
      if (result_valid_o && mem_ready_i)
      begin
        last_flags <= head.flags;
        rd_ptr     <= rd_ptr + 6'd1;
        pop_count  <= pop_count + 1;
      end
    end
  end

  a_output_expected: assert property (@(posedge clk) disable iff (!rst_n_i || flush_i)
    (result_valid_o && mem_ready_i) |-> (rd_ptr != wr_ptr))
    else stop_with_error("result left the pipeline with no request pending");

  a_result_match: assert property (@(posedge clk) disable iff (!rst_n_i || flush_i)
    (result_valid_o && mem_ready_i) |-> (result_o == head.result))
    else stop_with_error("result_o differs from the reference value");

  a_flags_match: assert property (@(posedge clk) disable iff (!rst_n_i || flush_i)
    (result_valid_o && mem_ready_i) |-> (flags_o == head.flags))
    else stop_with_error("flags_o differ from the reference flags");

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before all results arrived");
    $display("tests failed");
    $fatal(1, "timeout");
  end

  initial
  begin
    seed_ret      = $urandom(53537);
    rst_n_i       = 1'b0;
    flush_i       = 1'b0;
    req_valid_i   = 1'b0;
    req_i         = '0;
    mem_ready_i   = 1'b1;
    random_stalls = 1'b0;
    repeat (16) @(posedge clk);
    #2;
    rst_n_i = 1'b1;

    // Logic ops and MOV with the full mask
    for (i = 0; i < N_LOGIC; i++)
    begin
      j = $urandom_range(0, 5);
      send_request(make_req((j < 5) ? alu_opcode_t'(j) : OPC_MOV, rand_byte(), rand_byte(),
                            4'hf));
    end
    send_request(make_req(OPC_NEG, 8'h80, 8'h00, 4'hf));

    // ADD and SUB over the edge operands
    for (i = 0; i < 5; i++)
    begin
      for (j = 0; j < 5; j++)
      begin
        send_request(make_req(OPC_ADD, edge_operand(i), edge_operand(j), 4'hf));
        send_request(make_req(OPC_SUB, edge_operand(i), edge_operand(j), 4'hf));
      end
    end

    // Every shift amount with the upper bits of b set
    for (i = 0; i < 3; i++)
    begin
      for (j = 0; j < 8; j++)
      begin
        send_request(make_req(shift_opcode(i), 8'hb5, {5'b10110, 3'(j)}, 4'hf));
        send_request(make_req(shift_opcode(i), 8'h4c, {5'b01001, 3'(j)}, 4'hf));
      end
    end

    // Random masks and all opcodes under random stalls
    random_stalls = 1'b1;
    for (i = 0; i < N_MASKED; i++)
    begin
      send_request(make_req(alu_opcode_t'($urandom_range(0, 15)), rand_byte(), rand_byte(),
                            4'($urandom_range(0, 15))));
    end
    drain_pipeline();
    random_stalls = 1'b0;
    mem_ready_i   = 1'b1;
    idle_cycle();

    // Flush with one item held in commit and one in execute
    mem_ready_i = 1'b0;
    send_request(make_req(OPC_ADD, 8'h11, 8'h22, 4'h0));
    send_request(make_req(OPC_SUB, 8'h00, 8'h01, 4'hf));
    idle_cycle();
    req_i       = make_req(OPC_MOV, 8'h00, 8'h99, 4'hf);
    req_valid_i = 1'b1;
    flush_i     = 1'b1;
    @(posedge clk);
    #2;
    flush_i     = 1'b0;
    req_valid_i = 1'b0;
    mem_ready_i = 1'b1;
    repeat (4) idle_cycle();
    for (i = 0; i < N_AFTER_FLUSH; i++)
    begin
      send_request(make_req(alu_opcode_t'($urandom_range(0, 15)), rand_byte(), rand_byte(),
                            4'hf));
    end
    drain_pipeline();

    if (pop_count == EXPECTED_RESULTS)
    begin
      $display("all tests passed");
      $finish;
    end
    else
    begin
      stop_with_error($sformatf("%0d results seen, %0d expected", pop_count,
                                EXPECTED_RESULTS));
    end
  end

endmodule

`default_nettype wire

/* verilog/alu_adder_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_adder_unit
  import alu_pkg::*;
(
  input  alu_opcode_t op_i,
  input  alu_data_t   a_i,
  input  alu_data_t   b_i,
  output alu_data_t   result_o,
  output alu_flags_t  flags_o
);

  logic                is_sub;
  logic [DATA_WIDTH:0] wide;
  alu_data_t           res;
  logic                sign_a;
  logic                sign_b;
  logic                sign_r;
  logic                over;

  assign is_sub = (op_i == OPC_SUB);

  // Extra top bit holds carry-out for ADD and borrow for SUB
  always_comb
  begin
    if (is_sub)
    begin
      wide = {1'b0, a_i} - {1'b0, b_i};
    end
    else
    begin
      wide = {1'b0, a_i} + {1'b0, b_i};
    end
  end

  assign res    = wide[DATA_WIDTH-1:0];
  assign sign_a = a_i[DATA_WIDTH-1];
  assign sign_b = b_i[DATA_WIDTH-1];
  assign sign_r = res[DATA_WIDTH-1];

  // Signed overflow, operand signs compared against result sign
  assign over = is_sub ? ((sign_a != sign_b) && (sign_r != sign_a))
                       : ((sign_a == sign_b) && (sign_r != sign_a));

  assign result_o = res;

  always_comb
  begin
    flags_o.zero     = (res == '0);
    flags_o.negative = sign_r;
    flags_o.overflow = over;
    flags_o.carry    = wide[DATA_WIDTH];
  end

endmodule

`default_nettype wire

/* verilog/alu_execute.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_execute
  import alu_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n_i,
  input  logic      flush_i,
  input  logic      iss_valid_i,
  input  alu_req_t  iss_req_i,
  output logic      ex_ready_o,
  output logic      ex_valid_o,
  output alu_exec_t ex_out_o,
  input  logic      cm_ready_i
);

  alu_data_t  logic_res;
  alu_flags_t logic_flags;
  alu_data_t  add_res;
  alu_flags_t add_flags;
  alu_data_t  shift_res;
  alu_flags_t shift_flags;
  alu_exec_t  sel;
  logic       valid_q;
  alu_exec_t  out_q;

  alu_logic_unit u_logic (
    .op_i     (iss_req_i.opcode),
    .a_i      (iss_req_i.a),
    .b_i      (iss_req_i.b),
    .result_o (logic_res),
    .flags_o  (logic_flags)
  );

  alu_adder_unit u_adder (
    .op_i     (iss_req_i.opcode),
    .a_i      (iss_req_i.a),
    .b_i      (iss_req_i.b),
    .result_o (add_res),
    .flags_o  (add_flags)
  );

  alu_shift_unit u_shift (
    .op_i     (iss_req_i.opcode),
    .a_i      (iss_req_i.a),
    .shamt_i  (iss_req_i.b[SHAMT_WIDTH-1:0]),
    .result_o (shift_res),
    .flags_o  (shift_flags)
  );

  // Opcode dispatch
  always_comb
  begin
    sel.result = '0;
    sel.flags  = '0;
    sel.mask   = iss_req_i.mask;
    case (iss_req_i.opcode)
      OPC_AND, OPC_OR, OPC_XOR, OPC_NOT, OPC_NEG:
      begin
        sel.result = logic_res;
        sel.flags  = logic_flags;
      end
      OPC_ADD, OPC_SUB:
      begin
        sel.result = add_res;
        sel.flags  = add_flags;
      end
      OPC_LSR, OPC_LSL, OPC_ASR:
      begin
        sel.result = shift_res;
        sel.flags  = shift_flags;
      end
      OPC_MOV:
      begin
        sel.result = iss_req_i.b;
        sel.flags  = '0;
      end
      // Not implemented here, complete with 0 and keep the flags
      OPC_MUL, OPC_DIV, OPC_REM, OPC_SEX, OPC_ZEX:
      begin
        sel.result = '0;
        sel.flags  = '0;
        sel.mask   = '0;
      end
    endcase
  end

  assign ex_ready_o = !valid_q || cm_ready_i;

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      valid_q <= 1'b0;
    end
    else if (flush_i)
    begin
      valid_q <= 1'b0;
    end
    else if (ex_ready_o)
    begin
      valid_q <= iss_valid_i;
    end
  end

  always_ff @(posedge clk)
  begin
    if (ex_ready_o && iss_valid_i)
    begin
      out_q <= sel;
    end
  end

  assign ex_valid_o = valid_q;
  assign ex_out_o   = out_q;

endmodule

`default_nettype wire

/* verilog/alu_flag_commit.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_flag_commit
  import alu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       flush_i,
  input  logic       ex_valid_i,
  input  alu_exec_t  ex_in_i,
  output logic       cm_ready_o,
  input  logic       mem_ready_i,
  output logic       result_valid_o,
  output alu_data_t  result_o,
  output alu_flags_t flags_o
);

  logic       valid_q;
  alu_data_t  result_q;
  alu_flags_t flags_q;
  alu_flags_t flags_next;

  // Memory side is the sink
  assign cm_ready_o = !valid_q || mem_ready_i;

  // Previous flags with the masked bits replaced
  always_comb
  begin
    flags_next = flags_q;
    if (ex_in_i.mask[FLAG_ZERO])
    begin
      flags_next.zero = ex_in_i.flags.zero;
    end
    if (ex_in_i.mask[FLAG_NEG])
    begin
      flags_next.negative = ex_in_i.flags.negative;
    end
    if (ex_in_i.mask[FLAG_OVER])
    begin
      flags_next.overflow = ex_in_i.flags.overflow;
    end
    if (ex_in_i.mask[FLAG_CARRY])
    begin
      flags_next.carry = ex_in_i.flags.carry;
    end
  end

  // Flags move together with the result register load, never on flush
  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      valid_q <= 1'b0;
      flags_q <= '0;
    end
    else if (flush_i)
    begin
      valid_q <= 1'b0;
    end
    else if (cm_ready_o)
    begin
      valid_q <= ex_valid_i;
      if (ex_valid_i)
      begin
        flags_q <= flags_next;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (cm_ready_o && ex_valid_i)
    begin
      result_q <= ex_in_i.result;
    end
  end

  assign result_valid_o = valid_q;
  assign result_o       = result_q;
  assign flags_o        = flags_q;

endmodule

`default_nettype wire

/* verilog/alu_issue.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_issue
  import alu_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     flush_i,
  input  logic     req_valid_i,
  input  alu_req_t req_i,
  output logic     alu_ready_o,
  output logic     iss_valid_o,
  output alu_req_t iss_req_o,
  input  logic     ex_ready_i
);

  logic     valid_q;
  alu_req_t req_q;
  logic     load;

  // Free slot, or the held request moves to execute this cycle
  assign alu_ready_o = !valid_q || ex_ready_i;
  assign load        = alu_ready_o && req_valid_i;

  always_ff @(posedge clk)
  begin
    if (!rst_n_i)
    begin
      valid_q <= 1'b0;
    end
    else if (flush_i)
    begin
      valid_q <= 1'b0;
    end
    else if (alu_ready_o)
    begin
      valid_q <= req_valid_i;
    end
  end

  // Operand register, mask travels with the operands
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      req_q <= req_i;
    end
  end

  assign iss_valid_o = valid_q;
  assign iss_req_o   = req_q;

endmodule

`default_nettype wire

/* verilog/alu_logic_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_logic_unit
  import alu_pkg::*;
(
  input  alu_opcode_t op_i,
  input  alu_data_t   a_i,
  input  alu_data_t   b_i,
  output alu_data_t   result_o,
  output alu_flags_t  flags_o
);

  localparam alu_data_t MOST_NEGATIVE = {1'b1, {(DATA_WIDTH-1){1'b0}}};

  alu_data_t res;
  logic      neg_over;

  always_comb
  begin
    res      = '0;
    neg_over = 1'b0;
    case (op_i)
      OPC_AND: res = a_i & b_i;
      OPC_OR:  res = a_i | b_i;
      OPC_XOR: res = a_i ^ b_i;
      OPC_NOT: res = ~a_i;
      OPC_NEG:
      begin
        res      = -a_i;
        // Only the most negative value has no positive counterpart
        neg_over = (a_i == MOST_NEGATIVE);
      end
      default:
      begin
        res      = '0;
        neg_over = 1'b0;
      end
    endcase
  end

  assign result_o = res;

  always_comb
  begin
    flags_o.zero     = (res == '0);
    flags_o.negative = res[DATA_WIDTH-1];
    flags_o.overflow = neg_over;
    flags_o.carry    = 1'b0;
  end

endmodule

`default_nettype wire

/* verilog/alu_pkg.sv */
`default_nettype none

package alu_pkg;

  // Datapath widths
  localparam int DATA_WIDTH  = 8;
  localparam int SHAMT_WIDTH = 3;

  typedef logic [DATA_WIDTH-1:0]  alu_data_t;
  typedef logic [3:0]             alu_opcode_t;
  typedef logic [SHAMT_WIDTH-1:0] alu_shamt_t;

  // Opcode map, including the opcodes this core treats as illegal
  localparam alu_opcode_t OPC_AND = 4'h0;
  localparam alu_opcode_t OPC_OR  = 4'h1;
  localparam alu_opcode_t OPC_XOR = 4'h2;
  localparam alu_opcode_t OPC_NOT = 4'h3;
  localparam alu_opcode_t OPC_NEG = 4'h4;
  localparam alu_opcode_t OPC_MUL = 4'h5;
  localparam alu_opcode_t OPC_DIV = 4'h6;
  localparam alu_opcode_t OPC_REM = 4'h7;
  localparam alu_opcode_t OPC_ADD = 4'h8;
  localparam alu_opcode_t OPC_SUB = 4'h9;
  localparam alu_opcode_t OPC_SEX = 4'ha;
  localparam alu_opcode_t OPC_ZEX = 4'hb;
  localparam alu_opcode_t OPC_LSR = 4'hc;
  localparam alu_opcode_t OPC_LSL = 4'hd;
  localparam alu_opcode_t OPC_ASR = 4'he;
  localparam alu_opcode_t OPC_MOV = 4'hf;

  // Bit positions inside a flag mask
  localparam int FLAG_ZERO  = 0;
  localparam int FLAG_NEG   = 1;
  localparam int FLAG_OVER  = 2;
  localparam int FLAG_CARRY = 3;

  typedef struct packed {
    logic zero;
    logic negative;
    logic overflow;
    logic carry;
  } alu_flags_t;

  // Request as seen at the pipeline input, 24 bits
  typedef struct packed {
    alu_opcode_t opcode;
    alu_data_t   a;
    alu_data_t   b;
    logic [3:0]  mask;
  } alu_req_t;

  // Execute outcome handed to flag commit, 16 bits
  typedef struct packed {
    alu_data_t  result;
    alu_flags_t flags;
    logic [3:0] mask;
  } alu_exec_t;

endpackage

`default_nettype wire

/* verilog/alu_shift_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_shift_unit
  import alu_pkg::*;
(
  input  alu_opcode_t op_i,
  input  alu_data_t   a_i,
  input  alu_shamt_t  shamt_i,
  output alu_data_t   result_o,
  output alu_flags_t  flags_o
);

  // One guard bit beside the operand catches the last bit shifted out
  logic        [DATA_WIDTH:0] lsr_ext;
  logic        [DATA_WIDTH:0] lsl_ext;
  logic signed [DATA_WIDTH:0] asr_ext;
  alu_data_t                  res;
  logic                       carry;

  assign lsr_ext = {a_i, 1'b0} >> shamt_i;
  assign lsl_ext = {1'b0, a_i} << shamt_i;
  assign asr_ext = $signed({a_i, 1'b0}) >>> shamt_i;

  always_comb
  begin
    res   = '0;
    carry = 1'b0;
    case (op_i)
      OPC_LSR:
      begin
        res   = lsr_ext[DATA_WIDTH:1];
        carry = lsr_ext[0];
      end
      OPC_LSL:
      begin
        res   = lsl_ext[DATA_WIDTH-1:0];
        carry = lsl_ext[DATA_WIDTH];
      end
      OPC_ASR:
      begin
        res   = asr_ext[DATA_WIDTH:1];
        carry = asr_ext[0];
      end
      default:
      begin
        res   = '0;
        carry = 1'b0;
      end
    endcase
  end

  assign result_o = res;

  always_comb
  begin
    flags_o.zero     = (res == '0);
    flags_o.negative = res[DATA_WIDTH-1];
    flags_o.overflow = 1'b0;
    flags_o.carry    = carry;
  end

endmodule

`default_nettype wire

/* verilog/alu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_top
  import alu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n_i,
  input  logic       flush_i,
  input  logic       req_valid_i,
  input  alu_req_t   req_i,
  output logic       alu_ready_o,
  input  logic       mem_ready_i,
  output logic       result_valid_o,
  output alu_data_t  result_o,
  output alu_flags_t flags_o
);

  // Issue to execute
  logic      iss_valid;
  alu_req_t  iss_req;
  logic      ex_ready;
  // Execute to commit
  logic      ex_valid;
  alu_exec_t ex_out;
  logic      cm_ready;

  alu_issue u_issue (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .alu_ready_o (alu_ready_o),
    .iss_valid_o (iss_valid),
    .iss_req_o   (iss_req),
    .ex_ready_i  (ex_ready)
  );

  alu_execute u_execute (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .flush_i     (flush_i),
    .iss_valid_i (iss_valid),
    .iss_req_i   (iss_req),
    .ex_ready_o  (ex_ready),
    .ex_valid_o  (ex_valid),
    .ex_out_o    (ex_out),
    .cm_ready_i  (cm_ready)
  );

  alu_flag_commit u_commit (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .flush_i        (flush_i),
    .ex_valid_i     (ex_valid),
    .ex_in_i        (ex_out),
    .cm_ready_o     (cm_ready),
    .mem_ready_i    (mem_ready_i),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .flags_o        (flags_o)
  );

endmodule

`default_nettype wire
